//--- vlog.f
arch_pkg.sv
isa_pkg.sv
alu.sv
regfile.sv
pc_unit.sv
idec.sv
sequencer.sv
cpu.sv
cpu_props.sv
tb_cpu.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of tb_cpu

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
	-f vlog.f -o tb_cpu_sim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_cpu_sim +verilator+error+limit+100 > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error status"
	exit 1
fi
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
exit 0

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
	import arch_pkg::*;
	import isa_pkg::*;

	localparam int HALF_PERIOD = 50;
	localparam int RESET_CYCLES = 10;
	localparam int TIMEOUT_CYCLES = 5000;
	localparam logic [31:0] SEED = 32'h7d05_1615;
	localparam logic [15:0] RESULT_BASE = 16'h0300;
	localparam int NUM_RESULTS = 15;
	localparam logic [15:0] SKIP_ADDR = 16'h03f0;
	localparam logic [15:0] DONE_ADDR = 16'h03ff;
	localparam logic [7:0] ILLEGAL_OPC = 8'h02;

	logic clk = 1'b0;
	logic rst_n_i = 1'b0;
	logic rdy_i = 1'b1;
	logic [DATA_N-1:0] data_i;
	logic [DATA_N-1:0] data_o;
	logic [ADDR_N-1:0] addr_o;
	logic we_o;
	logic dbg_o;

	logic [7:0] mem [0:65535];
	logic [7:0] expected [NUM_RESULTS];
	string names [NUM_RESULTS];
	int hits [NUM_RESULTS];
	logic [15:0] load_ptr;
	int store_errors = 0;
	int other_errors = 0;
	int slot;
	logic done = 1'b0;

	cpu uut (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.rdy_i(rdy_i),
		.data_i(data_i),
		.data_o(data_o),
		.addr_o(addr_o),
		.we_o(we_o),
		.dbg_o(dbg_o)
	);

	bind cpu cpu_props bus_chk (
		.clk(clk), .rst_n_i(rst_n_i), .rdy_i(rdy_i), .addr_i(addr_o),
		.wdata_i(data_o), .we_i(we_o), .dbg_i(dbg_o)
	);

	always #HALF_PERIOD clk = ~clk;

	// Asynchronous read port of the memory model
	assign data_i = mem[addr_o];

	task automatic put_byte(input logic [7:0] b);
		mem[load_ptr] = b;
		load_ptr = load_ptr + 16'd1;
	endtask

	task automatic imm_instr(input logic [7:0] opc, input logic [7:0] val);
		put_byte(opc);
		put_byte(val);
	endtask

	task automatic abs_instr(input logic [7:0] opc, input logic [15:0] target);
		put_byte(opc);
		put_byte(target[7:0]);
		put_byte(target[15:8]);
	endtask

	// Emits the store and records what the 6502 would leave there
	task automatic store_result(input logic [7:0] opc, input int idx, input string label,
		input logic [7:0] value);
		abs_instr(opc, RESULT_BASE + 16'(idx));
		expected[idx] = value;
		names[idx] = label;
	endtask

	function automatic logic [8:0] add_with_carry(input logic [7:0] x, input logic [7:0] y,
		input logic c);
		add_with_carry = {1'b0, x} + {1'b0, y} + {8'b0, c};
	endfunction

	initial begin : load_program
		logic [8:0] sum;
		logic [7:0] ma;
		logic [7:0] mx;
		logic mc;
		logic [15:0] loop_addr;
		logic [15:0] rel;
		logic [15:0] jmp_addr;

		for (int i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h5c;
		load_ptr = RESET_PC;

		// Immediate loads and logic
		ma = 8'h5a;
		imm_instr(OPC_LDA, 8'h5a);
		store_result(OPC_STA, 0, "lda_imm", ma);
		ma = ma & 8'h0f;
		imm_instr(OPC_AND, 8'h0f);
		store_result(OPC_STA, 1, "and_imm", ma);
		ma = ma | 8'hc0;
		imm_instr(OPC_ORA, 8'hc0);
		store_result(OPC_STA, 2, "ora_imm", ma);
		ma = ma ^ 8'hff;
		imm_instr(OPC_EOR, 8'hff);
		store_result(OPC_STA, 3, "eor_imm", ma);
		mx = 8'h81;
		imm_instr(OPC_LDX, 8'h81);
		store_result(OPC_STX, 4, "ldx_imm", mx);

		// Carry out of one ADC feeds the next
		// SEC first so CLC has a carry to clear
		put_byte(OPC_SEC);
		put_byte(OPC_CLC);
		imm_instr(OPC_LDA, 8'hf0);
		imm_instr(OPC_ADC, 8'h20);
		sum = add_with_carry(8'hf0, 8'h20, 1'b0);
		mc = sum[8];
		store_result(OPC_STA, 5, "adc_after_clc", sum[7:0]);
		imm_instr(OPC_LDA, 8'h00);
		imm_instr(OPC_ADC, 8'h00);
		sum = add_with_carry(8'h00, 8'h00, mc);
		store_result(OPC_STA, 6, "adc_carry_set", sum[7:0]);
		put_byte(OPC_SEC);
		imm_instr(OPC_LDA, 8'h3f);
		imm_instr(OPC_ADC, 8'h40);
		sum = add_with_carry(8'h3f, 8'h40, 1'b1);
		mc = sum[8];
		store_result(OPC_STA, 7, "adc_after_sec", sum[7:0]);
		imm_instr(OPC_LDA, 8'h00);
		imm_instr(OPC_ADC, 8'h00);
		sum = add_with_carry(8'h00, 8'h00, mc);
		store_result(OPC_STA, 8, "adc_carry_clear", sum[7:0]);

		// X stepping and transfers
		imm_instr(OPC_LDX, 8'h00);
		put_byte(OPC_DEX);
		mx = 8'h00 - 8'd1;
		store_result(OPC_STX, 9, "dex_wrap", mx);
		put_byte(OPC_INX);
		mx = mx + 8'd1;
		store_result(OPC_STX, 10, "inx_wrap", mx);
		imm_instr(OPC_LDA, 8'h7e);
		put_byte(OPC_TAX);
		put_byte(OPC_INX);
		put_byte(OPC_TXA);
		ma = 8'h7e + 8'd1;
		store_result(OPC_STA, 11, "tax_inx_txa", ma);

		// Countdown loop adding 3 per pass
		imm_instr(OPC_LDX, 8'h05);
		imm_instr(OPC_LDA, 8'h00);
		loop_addr = load_ptr;
		put_byte(OPC_CLC);
		imm_instr(OPC_ADC, 8'h03);
		put_byte(OPC_DEX);
		put_byte(OPC_BNE);
		rel = loop_addr - (load_ptr + 16'd1);
		put_byte(rel[7:0]);
		mx = 8'h05;
		ma = 8'h00;
		do begin
			sum = add_with_carry(ma, 8'h03, 1'b0);
			ma = sum[7:0];
			mx = mx - 8'd1;
		end while (mx != 8'h00);
		store_result(OPC_STA, 12, "bne_loop_count", ma);
		store_result(OPC_STX, 13, "bne_loop_x", mx);

		// JMP over a store that must never happen
		jmp_addr = load_ptr;
		abs_instr(OPC_JMP, jmp_addr + 16'd6);
		abs_instr(OPC_STA, SKIP_ADDR);
		put_byte(OPC_NOP);
		put_byte(ILLEGAL_OPC);
		store_result(OPC_STA, 14, "nop_ill_keep_a", ma);

		abs_instr(OPC_STA, DONE_ADDR);
		jmp_addr = load_ptr;
		abs_instr(OPC_JMP, jmp_addr);
	end

	initial begin : drive_rdy
		void'($urandom(SEED));
		for (int i = 0; i < RESET_CYCLES + TIMEOUT_CYCLES + 2; i++) begin
			@(posedge clk);
			#1;
			// Low about one cycle in four
			rdy_i = ($urandom % 4) != 0;
		end
	end

	always @(posedge clk) begin
		if (rst_n_i && rdy_i && we_o) begin
			mem[addr_o] <= data_o;
			if (addr_o >= RESULT_BASE && addr_o < RESULT_BASE + NUM_RESULTS) begin
				slot = int'(addr_o - RESULT_BASE);
				hits[slot]++;
				assert (data_o == expected[slot])
				else begin
					store_errors++;
					$display("mismatch %s: expected %02h actual %02h",
						names[slot], expected[slot], data_o);
				end
			end else if (addr_o == DONE_ADDR) begin
				done <= 1'b1;
			end else begin
				store_errors++;
				$display("store to unexpected address %04h with data %02h", addr_o, data_o);
			end
		end
	end

	initial begin : main_flow
		int cycles;
		int bus_errors;

		cycles = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n_i = 1'b1;

		while (!done && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (!done) begin
			other_errors++;
			$display("program never finished: no store to %04h within %0d cycles",
				DONE_ADDR, TIMEOUT_CYCLES);
		end

		for (int i = 0; i < NUM_RESULTS; i++) begin
			if (hits[i] != 1) begin
				other_errors++;
				$display("result %s at %04h was stored %0d times instead of once",
					names[i], RESULT_BASE + 16'(i), hits[i]);
			end
		end

		bus_errors = uut.bus_chk.fail_cnt;
		$display("errors: %0d store, %0d bus assertion, %0d other",
			store_errors, bus_errors, other_errors);
		if (store_errors + bus_errors + other_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- cpu_props.sv
`timescale 1ns/1ps

module cpu_props (
	input logic clk,
	input logic rst_n_i,
	input logic rdy_i,
	input logic [arch_pkg::ADDR_N-1:0] addr_i,
	input logic [arch_pkg::DATA_N-1:0] wdata_i,
	input logic we_i,
	input logic dbg_i
);
	import arch_pkg::*;

	int fail_cnt = 0;

	// No write strobe while held in reset
	reset_no_write: assert property (@(posedge clk) !rst_n_i && $past(!rst_n_i) |-> !we_i)
	else begin
		fail_cnt++;
		$error("we_o high during reset");
	end

	// A stalled cycle keeps the whole bus
	stall_holds_bus: assert property (@(posedge clk)
		rst_n_i && !rdy_i |=> $stable(addr_i) && $stable(we_i) && $stable(wdata_i) &&
			$stable(dbg_i))
	else begin
		fail_cnt++;
		$error("bus changed while rdy_i was low");
	end

	// Opcode fetch is always a read
	fetch_not_write: assert property (@(posedge clk) rst_n_i |-> !(dbg_i && we_i))
	else begin
		fail_cnt++;
		$error("dbg_o and we_o high in the same cycle");
	end

	first_fetch: assert property (@(posedge clk)
		$rose(rst_n_i) |-> addr_i == RESET_PC && dbg_i && !we_i)
	else begin
		fail_cnt++;
		$error("first cycle after reset is not a fetch at the reset address");
	end

endmodule

//--- cpu.sv
`timescale 1ns/1ps

module cpu (
	input logic clk,
	input logic rst_n_i,
	input logic rdy_i,
	input logic [arch_pkg::DATA_N-1:0] data_i,
	output logic [arch_pkg::DATA_N-1:0] data_o,
	output logic [arch_pkg::ADDR_N-1:0] addr_o,
	output logic we_o,
	output logic dbg_o
);
	import arch_pkg::*;
	import isa_pkg::*;

	logic [DATA_N-1:0] ir, adl, adh, a, x, p;
	logic [DATA_N-1:0] alu_a, alu_b, alu_res;
	logic alu_cout, alu_ovf, alu_zero, alu_sign;
	logic [ADDR_N-1:0] pc;
	logic [3:0] flag_mask;
	logic [1:0] b_sel;
	logic addr_sel, pc_inc, pc_load, pc_branch;
	logic a_we, x_we, flags_en, set_c, clr_c;
	opcode_e opcode;
	mode_e mode;
	alu_func_e alu_func;

	// Data latch, holds the address high byte into the write cycle
	always_ff @(posedge clk) begin
		if (rdy_i)
			adh <= data_i;
	end

	assign addr_o = addr_sel ? {adh, adl} : pc;
	assign data_o = (opcode == OP_STX) ? x : a;

	// Only inc/dec take the constant one, and they step X
	assign alu_a = (b_sel == BSEL_ONE) ? x : a;

	always_comb begin
		case (b_sel)
			BSEL_ONE: alu_b = {{(DATA_N - 1){1'b0}}, 1'b1};
			BSEL_A: alu_b = a;
			BSEL_X: alu_b = x;
			default: alu_b = data_i;
		endcase
	end

	alu alu0 (.a_i(alu_a), .b_i(alu_b), .func_i(alu_func), .cin_i(p[STATUS_C]),
		.result_o(alu_res), .cout_o(alu_cout), .ovf_o(alu_ovf),
		.zero_o(alu_zero), .sign_o(alu_sign));

	regfile reg0 (.clk(clk), .rst_n_i(rst_n_i), .rdy_i(rdy_i),
		.alu_res_i(alu_res), .cout_i(alu_cout), .ovf_i(alu_ovf),
		.zero_i(alu_zero), .sign_i(alu_sign), .a_we_i(a_we), .x_we_i(x_we),
		.flag_mask_i(flag_mask & {4{flags_en}}), .set_c_i(set_c), .clr_c_i(clr_c),
		.a_o(a), .x_o(x), .p_o(p), .sp_o());

	pc_unit pc0 (.clk(clk), .rst_n_i(rst_n_i), .rdy_i(rdy_i), .inc_i(pc_inc),
		.load_i(pc_load), .branch_i(pc_branch), .load_addr_i({data_i, adl}),
		.offset_i(adl), .pc_o(pc));

	idec idec0 (.ir_i(ir), .opcode_o(opcode), .mode_o(mode),
		.alu_func_o(alu_func), .flag_mask_o(flag_mask));

	sequencer seq0 (.clk(clk), .rst_n_i(rst_n_i), .rdy_i(rdy_i), .data_i(data_i),
		.opcode_i(opcode), .mode_i(mode), .zflag_i(p[STATUS_Z]),
		.ir_o(ir), .adl_o(adl), .we_o(we_o), .dbg_o(dbg_o),
		.addr_sel_o(addr_sel), .pc_inc_o(pc_inc), .pc_load_o(pc_load),
		.pc_branch_o(pc_branch), .a_we_o(a_we), .x_we_o(x_we), .b_sel_o(b_sel),
		.flags_en_o(flags_en), .set_c_o(set_c), .clr_c_o(clr_c));

endmodule

//--- sequencer.sv
`timescale 1ns/1ps

module sequencer (
	input logic clk,
	input logic rst_n_i,
	input logic rdy_i,
	input logic [arch_pkg::DATA_N-1:0] data_i,
	input isa_pkg::opcode_e opcode_i,
	input isa_pkg::mode_e mode_i,
	input logic zflag_i,
	output logic [arch_pkg::DATA_N-1:0] ir_o,
	output logic [arch_pkg::DATA_N-1:0] adl_o,
	output logic we_o,
	output logic dbg_o,
	output logic addr_sel_o,
	output logic pc_inc_o,
	output logic pc_load_o,
	output logic pc_branch_o,
	output logic a_we_o,
	output logic x_we_o,
	output logic [1:0] b_sel_o,
	output logic flags_en_o,
	output logic set_c_o,
	output logic clr_c_o
);
	import isa_pkg::*;

	typedef enum logic [1:0] {S_FETCH, S_OP1, S_OP2, S_WRITE} state_e;

	state_e state_q, state_d;
	logic ir_we, adl_we, exec;

	always_comb begin
		case (opcode_i)
			OP_INX, OP_DEX: b_sel_o = BSEL_ONE;
			OP_TAX: b_sel_o = BSEL_A;
			OP_TXA: b_sel_o = BSEL_X;
			default: b_sel_o = BSEL_MEM;
		endcase
	end

	always_comb begin
		state_d = S_FETCH;
		we_o = 1'b0;
		dbg_o = 1'b0;
		addr_sel_o = 1'b0;
		pc_inc_o = 1'b0;
		pc_load_o = 1'b0;
		pc_branch_o = 1'b0;
		ir_we = 1'b0;
		adl_we = 1'b0;
		exec = 1'b0;
		case (state_q)
			S_FETCH: begin
				dbg_o = 1'b1;
				ir_we = 1'b1;
				pc_inc_o = 1'b1;
				state_d = S_OP1;
			end
			S_OP1: begin
				case (mode_i)
					MODE_IMM: begin
						pc_inc_o = 1'b1;
						exec = 1'b1;
					end
					MODE_ABS: begin
						pc_inc_o = 1'b1;
						adl_we = 1'b1;
						state_d = S_OP2;
					end
					MODE_REL: begin
						pc_inc_o = 1'b1;
						adl_we = 1'b1;
						// Extra cycle only when the branch is taken
						if (opcode_i == OP_BNE && !zflag_i)
							state_d = S_OP2;
					end
					// Implied, second cycle is a dummy read at pc
					default: exec = 1'b1;
				endcase
			end
			S_OP2: begin
				if (mode_i == MODE_REL) begin
					pc_branch_o = 1'b1;
				end else if (opcode_i == OP_JMP) begin
					pc_load_o = 1'b1;
				end else begin
					pc_inc_o = 1'b1;
					state_d = S_WRITE;
				end
			end
			default: begin
				addr_sel_o = 1'b1;
				we_o = 1'b1;
			end
		endcase
	end

	assign a_we_o = exec && (opcode_i inside {OP_LDA, OP_ADC, OP_AND, OP_ORA, OP_EOR, OP_TXA});
	assign x_we_o = exec && (opcode_i inside {OP_LDX, OP_INX, OP_DEX, OP_TAX});
	assign flags_en_o = exec;
	assign set_c_o = exec && (opcode_i == OP_SEC);
	assign clr_c_o = exec && (opcode_i == OP_CLC);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= S_FETCH;
			ir_o <= OPC_NOP;
		end else if (rdy_i) begin
			state_q <= state_d;
			if (ir_we)
				ir_o <= data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rdy_i && adl_we)
			adl_o <= data_i;
	end

endmodule

//--- idec.sv
`timescale 1ns/1ps

module idec (
	input logic [arch_pkg::DATA_N-1:0] ir_i,
	output isa_pkg::opcode_e opcode_o,
	output isa_pkg::mode_e mode_o,
	output isa_pkg::alu_func_e alu_func_o,
	output logic [3:0] flag_mask_o
);
	import isa_pkg::*;

	localparam logic [3:0] MASK_NZ = 4'b1010;
	localparam logic [3:0] MASK_NVZC = 4'b1111;

	always_comb begin
		opcode_o = OP_ILL;
		mode_o = MODE_IMP;
		alu_func_o = ALU_PASS;
		flag_mask_o = 4'b0000;
		case (ir_i)
			OPC_LDA: begin opcode_o = OP_LDA; mode_o = MODE_IMM; flag_mask_o = MASK_NZ; end
			OPC_LDX: begin opcode_o = OP_LDX; mode_o = MODE_IMM; flag_mask_o = MASK_NZ; end
			OPC_ADC: begin
				opcode_o = OP_ADC;
				mode_o = MODE_IMM;
				alu_func_o = ALU_ADC;
				flag_mask_o = MASK_NVZC;
			end
			OPC_AND: begin
				opcode_o = OP_AND;
				mode_o = MODE_IMM;
				alu_func_o = ALU_AND;
				flag_mask_o = MASK_NZ;
			end
			OPC_ORA: begin
				opcode_o = OP_ORA;
				mode_o = MODE_IMM;
				alu_func_o = ALU_ORA;
				flag_mask_o = MASK_NZ;
			end
			OPC_EOR: begin
				opcode_o = OP_EOR;
				mode_o = MODE_IMM;
				alu_func_o = ALU_EOR;
				flag_mask_o = MASK_NZ;
			end
			OPC_STA: begin opcode_o = OP_STA; mode_o = MODE_ABS; end
			OPC_STX: begin opcode_o = OP_STX; mode_o = MODE_ABS; end
			OPC_INX: begin opcode_o = OP_INX; alu_func_o = ALU_INC; flag_mask_o = MASK_NZ; end
			OPC_DEX: begin opcode_o = OP_DEX; alu_func_o = ALU_DEC; flag_mask_o = MASK_NZ; end
			OPC_TAX: begin opcode_o = OP_TAX; flag_mask_o = MASK_NZ; end
			OPC_TXA: begin opcode_o = OP_TXA; flag_mask_o = MASK_NZ; end
			OPC_CLC: opcode_o = OP_CLC;
			OPC_SEC: opcode_o = OP_SEC;
			OPC_JMP: begin opcode_o = OP_JMP; mode_o = MODE_ABS; end
			OPC_BNE: begin opcode_o = OP_BNE; mode_o = MODE_REL; end
			OPC_NOP: opcode_o = OP_NOP;
			default: ;
		endcase
	end

endmodule

//--- pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
	input logic clk,
	input logic rst_n_i,
	input logic rdy_i,
	input logic inc_i,
	input logic load_i,
	input logic branch_i,
	input logic [arch_pkg::ADDR_N-1:0] load_addr_i,
	input logic [arch_pkg::DATA_N-1:0] offset_i,
	output logic [arch_pkg::ADDR_N-1:0] pc_o
);
	import arch_pkg::*;

	logic [ADDR_N-1:0] pc_q;
	logic [ADDR_N-1:0] offset_ext;

	// pc already points past the offset byte when the branch is taken
	assign offset_ext = {{(ADDR_N - DATA_N){offset_i[DATA_N-1]}}, offset_i};

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q <= RESET_PC;
		end else if (rdy_i) begin
			if (load_i)
				pc_q <= load_addr_i;
			else if (branch_i)
				pc_q <= pc_q + offset_ext;
			else if (inc_i)
				pc_q <= pc_q + 1'b1;
		end
	end

	assign pc_o = pc_q;

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic rst_n_i,
	input logic rdy_i,
	input logic [arch_pkg::DATA_N-1:0] alu_res_i,
	input logic cout_i,
	input logic ovf_i,
	input logic zero_i,
	input logic sign_i,
	input logic a_we_i,
	input logic x_we_i,
	input logic [3:0] flag_mask_i,
	input logic set_c_i,
	input logic clr_c_i,
	output logic [arch_pkg::DATA_N-1:0] a_o,
	output logic [arch_pkg::DATA_N-1:0] x_o,
	output logic [arch_pkg::DATA_N-1:0] p_o,
	output logic [arch_pkg::DATA_N-1:0] sp_o
);
	import arch_pkg::*;
	import isa_pkg::*;

	logic [DATA_N-1:0] a_q, x_q, p_q;
	logic [DATA_N-1:0] p_next;

	// Mask order is N V Z C
	always_comb begin
		p_next = p_q;
		if (flag_mask_i[3])
			p_next[STATUS_N] = sign_i;
		if (flag_mask_i[2])
			p_next[STATUS_V] = ovf_i;
		if (flag_mask_i[1])
			p_next[STATUS_Z] = zero_i;
		if (flag_mask_i[0])
			p_next[STATUS_C] = cout_i;
		if (set_c_i)
			p_next[STATUS_C] = 1'b1;
		if (clr_c_i)
			p_next[STATUS_C] = 1'b0;
		p_next[STATUS_R] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			a_q <= '0;
			x_q <= '0;
			p_q <= P_RESET;
		end else if (rdy_i) begin
			if (a_we_i)
				a_q <= alu_res_i;
			if (x_we_i)
				x_q <= alu_res_i;
			p_q <= p_next;
		end
	end

	assign a_o = a_q;
	assign x_o = x_q;
	assign p_o = p_q;
	// SP keeps its reset value since no stack instruction is decoded
	assign sp_o = SP_RESET;

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
	input logic [arch_pkg::DATA_N-1:0] a_i,
	input logic [arch_pkg::DATA_N-1:0] b_i,
	input isa_pkg::alu_func_e func_i,
	input logic cin_i,
	output logic [arch_pkg::DATA_N-1:0] result_o,
	output logic cout_o,
	output logic ovf_o,
	output logic zero_o,
	output logic sign_o
);
	import arch_pkg::*;
	import isa_pkg::*;

	logic [DATA_N:0] sum;

	always_comb begin
		sum = {1'b0, a_i} + {1'b0, b_i} + {{DATA_N{1'b0}}, cin_i};
		result_o = b_i;
		// Carry passes through unless ADC computes a new one
		cout_o = cin_i;
		ovf_o = 1'b0;
		case (func_i)
			ALU_ADC: begin
				result_o = sum[DATA_N-1:0];
				cout_o = sum[DATA_N];
				// Signed overflow when both inputs agree in sign and the result does not
				ovf_o = (a_i[DATA_N-1] == b_i[DATA_N-1]) &&
					(sum[DATA_N-1] != a_i[DATA_N-1]);
			end
			ALU_AND: result_o = a_i & b_i;
			ALU_ORA: result_o = a_i | b_i;
			ALU_EOR: result_o = a_i ^ b_i;
			ALU_INC: result_o = a_i + b_i;
			ALU_DEC: result_o = a_i - b_i;
			default: result_o = b_i;
		endcase
	end

	assign zero_o = (result_o == '0);
	assign sign_o = result_o[DATA_N-1];

endmodule

//--- isa_pkg.sv
package isa_pkg;

	typedef enum logic [4:0] {
		OP_LDA, OP_LDX, OP_ADC, OP_AND, OP_ORA, OP_EOR,
		OP_STA, OP_STX, OP_INX, OP_DEX, OP_TAX, OP_TXA,
		OP_CLC, OP_SEC, OP_JMP, OP_BNE, OP_NOP, OP_ILL
	} opcode_e;

	typedef enum logic [1:0] {
		MODE_IMP, MODE_IMM, MODE_ABS, MODE_REL
	} mode_e;

	typedef enum logic [2:0] {
		ALU_ADC, ALU_AND, ALU_ORA, ALU_EOR, ALU_INC, ALU_DEC, ALU_PASS
	} alu_func_e;

	// Bit positions within P
	localparam int STATUS_C = 0;
	localparam int STATUS_Z = 1;
	localparam int STATUS_I = 2;
	localparam int STATUS_R = 5;
	localparam int STATUS_V = 6;
	localparam int STATUS_N = 7;

	// ALU B operand sources
	localparam logic [1:0] BSEL_MEM = 2'd0;
	localparam logic [1:0] BSEL_ONE = 2'd1;
	localparam logic [1:0] BSEL_A = 2'd2;
	localparam logic [1:0] BSEL_X = 2'd3;

	// Opcode bytes
	localparam logic [7:0] OPC_LDA = 8'ha9;
	localparam logic [7:0] OPC_LDX = 8'ha2;
	localparam logic [7:0] OPC_ADC = 8'h69;
	localparam logic [7:0] OPC_AND = 8'h29;
	localparam logic [7:0] OPC_ORA = 8'h09;
	localparam logic [7:0] OPC_EOR = 8'h49;
	localparam logic [7:0] OPC_STA = 8'h8d;
	localparam logic [7:0] OPC_STX = 8'h8e;
	localparam logic [7:0] OPC_INX = 8'he8;
	localparam logic [7:0] OPC_DEX = 8'hca;
	localparam logic [7:0] OPC_TAX = 8'haa;
	localparam logic [7:0] OPC_TXA = 8'h8a;
	localparam logic [7:0] OPC_CLC = 8'h18;
	localparam logic [7:0] OPC_SEC = 8'h38;
	localparam logic [7:0] OPC_JMP = 8'h4c;
	localparam logic [7:0] OPC_BNE = 8'hd0;
	localparam logic [7:0] OPC_NOP = 8'hea;

endpackage

//--- arch_pkg.sv
package arch_pkg;

	// Bus widths
	localparam int DATA_N = 8;
	localparam int ADDR_N = 16;

	// First opcode fetch after reset
	localparam logic [ADDR_N-1:0] RESET_PC = 16'h0200;

	// Stack pointer starts at the top of page one
	localparam logic [DATA_N-1:0] SP_RESET = 8'hff;

	// I flag and the always-one bit set
	localparam logic [DATA_N-1:0] P_RESET = 8'h24;

endpackage
